/* rv_isa_pkg.sv */
//************************************************
// rv64 encoding: data width, major opcodes, funct
// values, instruction field layout, ebreak word
//************************************************

package rv_isa_pkg;

  // register and data path width
  localparam int xlen = 64;

  // major opcodes of the kept subset
  typedef enum logic [6:0] {
    op     = 7'b0110011,
    op_imm = 7'b0010011,
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111,
    load   = 7'b0000011,
    store  = 7'b0100011,
    system = 7'b1110011
  } opcode_e;

  // funct3 for add/addi
  localparam logic [2:0] funct3_add = 3'b000;
  // funct3 for doubleword ld/sd
  localparam logic [2:0] funct3_d   = 3'b011;

  // r/i/s field layout, msb first
  // immediates are rebuilt from the raw word in the decoder
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } inst_t;

  // ebreak, system opcode with imm 1
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

endpackage

/* rv_core_pkg.sv */
//************************************************
// core types: run state, alu ops, decoded inst,
// retire trace and memory load request
//************************************************

package rv_core_pkg;

  // run control states
  typedef enum logic [1:0] {
    idle    = 2'd0,
    run     = 2'd1,
    halted  = 2'd2,
    trapped = 2'd3
  } core_state_e;

  // alu ops, add also covers auipc and addresses
  typedef enum logic {
    add    = 1'b0,
    pass_b = 1'b1
  } alu_op_e;

  // decoder output
  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [63:0] imm;
    alu_op_e     alu_op;
    logic        use_imm;    // operand b from imm
    logic        use_pc;     // operand a from pc
    logic        reg_wen;
    logic        mem_ren;
    logic        mem_wen;
    logic        is_jal;
    logic        is_ebreak;
    logic        illegal;
  } dec_t;

  // one committed instruction
  // mem_addr is the 64-bit word index, address bits 32:3
  typedef struct packed {
    logic [63:0] pc;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic        rd_wen;
    logic [63:0] rd_data;
    logic        mem_wen;
    logic [29:0] mem_addr;
  } retire_t;

  // external memory fill, one word per strobe
  typedef struct packed {
    logic        en;
    logic [31:0] idx;
    logic [63:0] data;
  } load_req_t;

endpackage

/* rv_decoder.sv */
//************************************************
// combinational decoder, inst word to dec_t
//************************************************

`timescale 1ns/10ps

module rv_decoder (
  input  logic [31:0]        inst,
  output rv_core_pkg::dec_t  dec
);

  rv_isa_pkg::inst_t f;
  logic [63:0] imm_i;
  logic [63:0] imm_s;
  logic [63:0] imm_u;
  logic [63:0] imm_j;

  assign f = rv_isa_pkg::inst_t'(inst);

  // sign-extended immediates, all taken from bit 31
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    dec.rd     = f.rd;
    dec.rs1    = f.rs1;
    dec.rs2    = f.rs2;
    dec.alu_op = rv_core_pkg::add;
    case (f.opcode)
      rv_isa_pkg::op: begin
        // add only, sub and others trap
        dec.reg_wen = 1'b1;
        dec.illegal = (f.funct3 != rv_isa_pkg::funct3_add) || (f.funct7 != 7'd0);
      end
      rv_isa_pkg::op_imm: begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
        dec.illegal = f.funct3 != rv_isa_pkg::funct3_add;
      end
      rv_isa_pkg::lui: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op  = rv_core_pkg::pass_b;
        dec.reg_wen = 1'b1;
      end
      rv_isa_pkg::auipc: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.use_pc  = 1'b1;
        dec.reg_wen = 1'b1;
      end
      rv_isa_pkg::jal: begin
        // link value and target built in top
        dec.imm     = imm_j;
        dec.is_jal  = 1'b1;
        dec.reg_wen = 1'b1;
      end
      rv_isa_pkg::load: begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.mem_ren = 1'b1;
        dec.reg_wen = 1'b1;
        dec.illegal = f.funct3 != rv_isa_pkg::funct3_d;
      end
      rv_isa_pkg::store: begin
        dec.imm     = imm_s;
        dec.use_imm = 1'b1;
        dec.mem_wen = 1'b1;
        dec.illegal = f.funct3 != rv_isa_pkg::funct3_d;
      end
      rv_isa_pkg::system: begin
        // only the exact ebreak word, ecall and csr ops trap
        dec.is_ebreak = inst == rv_isa_pkg::ebreak_word;
        dec.illegal   = inst != rv_isa_pkg::ebreak_word;
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
    // no side effects from a trapping word
    if (dec.illegal) begin
      dec.reg_wen = 1'b0;
      dec.mem_ren = 1'b0;
      dec.mem_wen = 1'b0;
      dec.is_jal  = 1'b0;
    end
  end

endmodule

/* rv_regfile.sv */
//************************************************
// 32 x 64 register file, x0 reads as zero
//************************************************

`timescale 1ns/10ps

module rv_regfile (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [4:0]                  rs1,
  input  logic [4:0]                  rs2,
  input  logic [4:0]                  rd,
  input  logic [rv_isa_pkg::xlen-1:0] wdata,
  input  logic                        wen,
  output logic [rv_isa_pkg::xlen-1:0] rdata_1,
  output logic [rv_isa_pkg::xlen-1:0] rdata_2
);

  // x1..x31 only, x0 has no storage
  logic [rv_isa_pkg::xlen-1:0] regs_q [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wen && (rd != 5'd0)) begin
      // writes to x0 dropped here
      regs_q[rd] <= wdata;
    end
  end

  // async read ports
  always_comb begin
    rdata_1 = '0;
    rdata_2 = '0;
    if (rs1 != 5'd0) begin
      rdata_1 = regs_q[rs1];
    end
    if (rs2 != 5'd0) begin
      rdata_2 = regs_q[rs2];
    end
  end

endmodule

/* rv_alu.sv */
//************************************************
// alu, 64-bit add or pass of operand b
//************************************************

`timescale 1ns/10ps

module rv_alu (
  input  rv_core_pkg::alu_op_e         op,
  input  logic [rv_isa_pkg::xlen-1:0]  a,
  input  logic [rv_isa_pkg::xlen-1:0]  b,
  output logic [rv_isa_pkg::xlen-1:0]  result
);

  always_comb begin
    case (op)
      // add, addi, auipc, ld/sd address
      rv_core_pkg::add: begin
        result = a + b;
      end
      // lui, upper imm straight through
      rv_core_pkg::pass_b: begin
        result = b;
      end
      default: begin
        result = a + b;
      end
    endcase
  end

endmodule

/* rv_memory.sv */
//************************************************
// unified word memory, fetch, ld/sd, fill port
//************************************************

`timescale 1ns/10ps

module rv_memory #(
  parameter int mem_words = 1024
) (
  input  logic                   clk,
  input  logic [63:0]            pc,
  output logic [31:0]            inst,
  input  logic [63:0]            addr,
  output logic [63:0]            rdata,
  input  logic [63:0]            wdata,
  input  logic                   wen,
  input  rv_core_pkg::load_req_t load
);

  // index width, depth taken as a power of two
  localparam int aw = $clog2(mem_words);

  logic [63:0]   mem_q [mem_words];
  logic [aw-1:0] fetch_idx;
  logic [aw-1:0] data_idx;
  logic [aw-1:0] load_idx;
  logic [63:0]   fetch_word;

  // byte address to word index, upper bits wrap
  assign fetch_idx = pc[aw+2:3];
  assign data_idx  = addr[aw+2:3];
  assign load_idx  = load.idx[aw-1:0];

  // combinational reads
  assign fetch_word = mem_q[fetch_idx];
  assign rdata      = mem_q[data_idx];

  // pc bit 2 picks the 32-bit half
  assign inst = pc[2] ? fetch_word[63:32] : fetch_word[31:0];

  always_ff @(posedge clk) begin
    // core store
    if (wen) begin
      mem_q[data_idx] <= wdata;
    end
    // fill port last, so it wins on the same word
    if (load.en) begin
      mem_q[load_idx] <= load.data;
    end
  end

endmodule

/* rv_pc_counter.sv */
//************************************************
// program counter, +4 or jump, reload on start
//************************************************

`timescale 1ns/10ps

module rv_pc_counter #(
  parameter logic [63:0] pc_reset = 64'd0
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        restart,
  input  logic        advance,
  input  logic        jump,
  input  logic [63:0] target,
  output logic [63:0] pc
);

  logic [63:0] pc_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= pc_reset;
    end else if (restart) begin
      // rerun from the start address
      pc_q <= pc_reset;
    end else if (advance) begin
      // jal target or sequential
      pc_q <= jump ? target : pc_q + 64'd4;
    end
    // otherwise hold, covers halt and trap
  end

  assign pc = pc_q;

endmodule

/* rv_core_ctrl.sv */
//************************************************
// run control fsm: idle, run, halted, trapped
//************************************************

`timescale 1ns/10ps

module rv_core_ctrl (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     start,
  input  logic                     is_ebreak,
  input  logic                     illegal,
  output rv_core_pkg::core_state_e state,
  output logic                     restart,
  output logic                     commit
);

  rv_core_pkg::core_state_e state_q;
  rv_core_pkg::core_state_e state_d;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= rv_core_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      rv_core_pkg::run: begin
        // trap wins, ebreak is legal
        if (illegal) begin
          state_d = rv_core_pkg::trapped;
        end else if (is_ebreak) begin
          state_d = rv_core_pkg::halted;
        end
      end
      default: begin
        // idle, halted, trapped all wait for start
        if (start) begin
          state_d = rv_core_pkg::run;
        end
      end
    endcase
  end

  // start ignored while running
  assign restart = start && (state_q != rv_core_pkg::run);
  // one legal instruction per run cycle
  assign commit  = (state_q == rv_core_pkg::run) && !illegal;
  assign state   = state_q;

endmodule

/* rv_core_top.sv */
//************************************************
// single-cycle rv64 core top: muxes, retire trace
//************************************************

`timescale 1ns/10ps

module rv_core_top #(
  parameter int          mem_words = 1024,
  parameter logic [63:0] pc_reset  = 64'd0
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     start,
  input  rv_core_pkg::load_req_t   load,
  output logic                     retire_valid,
  output rv_core_pkg::retire_t     retire,
  output rv_core_pkg::core_state_e state
);

  logic [63:0]       pc;
  logic [31:0]       inst;
  rv_core_pkg::dec_t dec;
  logic [63:0]       rdata_1;
  logic [63:0]       rdata_2;
  logic [63:0]       op_a;
  logic [63:0]       op_b;
  logic [63:0]       alu_result;
  logic [63:0]       mem_rdata;
  logic [63:0]       wb_data;
  logic [63:0]       pc_plus4;
  logic [63:0]       jump_target;
  logic              commit;
  logic              restart;
  logic              advance;

  rv_pc_counter #(.pc_reset(pc_reset)) pc_i (
    .clk(clk), .arst_n(arst_n), .restart(restart), .advance(advance),
    .jump(dec.is_jal), .target(jump_target), .pc(pc)
  );

  // alu result doubles as the ld/sd address, rs2 is store data
  rv_memory #(.mem_words(mem_words)) mem_i (
    .clk(clk), .pc(pc), .inst(inst), .addr(alu_result), .rdata(mem_rdata),
    .wdata(rdata_2), .wen(commit && dec.mem_wen), .load(load)
  );

  rv_decoder dec_i (.inst(inst), .dec(dec));

  rv_regfile rf_i (
    .clk(clk), .arst_n(arst_n), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
    .wdata(wb_data), .wen(commit && dec.reg_wen), .rdata_1(rdata_1), .rdata_2(rdata_2)
  );

  // operand muxes
  assign op_a = dec.use_pc ? pc : rdata_1;
  assign op_b = dec.use_imm ? dec.imm : rdata_2;

  rv_alu alu_i (.op(dec.alu_op), .a(op_a), .b(op_b), .result(alu_result));

  rv_core_ctrl ctrl_i (
    .clk(clk), .arst_n(arst_n), .start(start), .is_ebreak(dec.is_ebreak),
    .illegal(dec.illegal), .state(state), .restart(restart), .commit(commit)
  );

  assign pc_plus4    = pc + 64'd4;
  assign jump_target = pc + dec.imm;
  // pc stays on ebreak
  assign advance     = commit && !dec.is_ebreak;

  // write-back priority: link, load, alu
  assign wb_data = dec.is_jal  ? pc_plus4  :
                   dec.mem_ren ? mem_rdata : alu_result;

  // trace of the instruction committing this cycle
  assign retire_valid = commit;
  always_comb begin
    retire.pc       = pc;
    retire.inst     = inst;
    retire.rd       = dec.rd;
    retire.rd_wen   = commit && dec.reg_wen;
    retire.rd_data  = wb_data;
    retire.mem_wen  = commit && dec.mem_wen;
    retire.mem_addr = alu_result[32:3];
  end

endmodule

/* tb_rv_core.sv */
//************************************************
// testbench for the rv64 core with lfsr, encoders,
// isa reference model and directed tests
//************************************************

`timescale 1ns/10ps

module tb_rv_core;

  logic                     clk = 1'b0;
  logic                     arst_n;
  logic                     start;
  rv_core_pkg::load_req_t   load;
  logic                     retire_valid;
  rv_core_pkg::retire_t     retire;
  rv_core_pkg::core_state_e state;

  logic [31:0] lfsr_q = 32'hb3d9_5578;
  // reference model state
  logic [63:0] m_x [32];
  logic [63:0] m_mem [1024];
  logic [63:0] m_pc;
  logic [31:0] prog [$];

  rv_core_top #(.mem_words(1024), .pc_reset(64'd0)) dut_i (
    .clk(clk), .arst_n(arst_n), .start(start), .load(load),
    .retire_valid(retire_valid), .retire(retire), .state(state)
  );

  always #20 clk = ~clk;

  // fibonacci lfsr with taps 32 22 2 1
  // one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // instruction encoders
  function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [4:0] rd, rs1,
                                         input logic [2:0] f3, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, rv_isa_pkg::funct3_add, rd, rv_isa_pkg::op};
  endfunction
  function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction
  function automatic logic [31:0] s_type(input logic [4:0] rs1, rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, rv_isa_pkg::funct3_d, imm[4:0], rv_isa_pkg::store};
  endfunction
  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::jal};
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
    assert (got === want)
    else stop_with_error($sformatf("FAIL %s got %h expected %h", name, got, want));
  endtask

  // drive point 2 ns past the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // isa model steps one instruction and returns the expected trace entry
  task automatic model_step(input logic [31:0] w, output rv_core_pkg::retire_t e,
                            output logic halt, output logic ill);
    rv_isa_pkg::inst_t f;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] addr;
    logic [63:0] nxt;
    f = rv_isa_pkg::inst_t'(w);
    a = m_x[f.rs1];
    b = m_x[f.rs2];
    e = '0;
    e.pc = m_pc;
    e.inst = w;
    e.rd = f.rd;
    halt = 1'b0;
    ill = 1'b0;
    nxt = m_pc + 64'd4;
    case (f.opcode)
      rv_isa_pkg::op: begin
        ill = (f.funct3 != rv_isa_pkg::funct3_add) || (f.funct7 != 7'd0);
        e.rd_data = a + b;
      end
      rv_isa_pkg::op_imm: begin
        ill = f.funct3 != rv_isa_pkg::funct3_add;
        e.rd_data = a + {{52{w[31]}}, w[31:20]};
      end
      rv_isa_pkg::lui: e.rd_data = {{32{w[31]}}, w[31:12], 12'd0};
      rv_isa_pkg::auipc: e.rd_data = m_pc + {{32{w[31]}}, w[31:12], 12'd0};
      rv_isa_pkg::jal: begin
        // link is the next sequential pc
        e.rd_data = m_pc + 64'd4;
        nxt = m_pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      rv_isa_pkg::load: begin
        ill = f.funct3 != rv_isa_pkg::funct3_d;
        addr = a + {{52{w[31]}}, w[31:20]};
        e.rd_data = m_mem[addr[12:3]];
      end
      rv_isa_pkg::store: begin
        ill = f.funct3 != rv_isa_pkg::funct3_d;
        addr = a + {{52{w[31]}}, w[31:25], w[11:7]};
        e.mem_wen = 1'b1;
        e.mem_addr = addr[32:3];
        if (!ill)
          m_mem[addr[12:3]] = b;
      end
      rv_isa_pkg::system: begin
        // pc stays put on ebreak
        halt = w == rv_isa_pkg::ebreak_word;
        ill = !halt;
        nxt = m_pc;
      end
      default: ill = 1'b1;
    endcase
    e.rd_wen = !ill && !halt && (f.opcode != rv_isa_pkg::store);
    if (e.rd_wen && (f.rd != 5'd0))
      m_x[f.rd] = e.rd_data;
    if (!ill)
      m_pc = nxt;
  endtask

  task automatic write_word(input logic [31:0] idx, input logic [63:0] data);
    load.en = 1'b1;
    load.idx = idx;
    load.data = data;
    m_mem[idx[9:0]] = data;
    next_cycle();
    load.en = 1'b0;
  endtask

  // two instructions per word and an odd tail padded with zero
  task automatic load_program();
    for (int i = 0; i < prog.size(); i += 2) begin
      write_word(32'(i / 2), {(i + 1 < prog.size()) ? prog[i + 1] : 32'd0, prog[i]});
    end
  endtask

  task automatic expect_retire(input rv_core_pkg::retire_t e);
    int n;
    n = 0;
    while (!retire_valid) begin
      @(negedge clk);
      n++;
      assert (n < 10) else stop_with_error("timed out waiting for retire_valid");
    end
    check_value("retire.pc", retire.pc, e.pc);
    check_value("retire.inst", 64'(retire.inst), 64'(e.inst));
    check_value("retire.rd", 64'(retire.rd), 64'(e.rd));
    check_value("retire.rd_wen", 64'(retire.rd_wen), 64'(e.rd_wen));
    if (e.rd_wen)
      check_value("retire.rd_data", retire.rd_data, e.rd_data);
    check_value("retire.mem_wen", 64'(retire.mem_wen), 64'(e.mem_wen));
    if (e.mem_wen)
      check_value("retire.mem_addr", 64'(retire.mem_addr), 64'(e.mem_addr));
  endtask

  // wait for the end state, then make sure the core stays quiet
  // and the pc stays frozen on the last word
  task automatic settle_in(input rv_core_pkg::core_state_e s);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      check_value("retire_valid", 64'(retire_valid), 64'd0);
      n++;
      assert (n < 10) else stop_with_error("core never reached the expected state");
    end while (state != s);
    repeat (3) begin
      @(negedge clk);
      check_value("retire_valid", 64'(retire_valid), 64'd0);
      check_value("state", 64'(state), 64'(s));
      check_value("retire.pc", retire.pc, m_pc);
    end
    next_cycle();
  endtask

  task automatic run_program(input rv_core_pkg::core_state_e end_state);
    logic [63:0] word;
    logic [31:0] w;
    rv_core_pkg::retire_t e;
    logic halt;
    logic ill;
    int n;
    start = 1'b1;
    m_pc = 64'd0;
    next_cycle();
    start = 1'b0;
    halt = 1'b0;
    ill = 1'b0;
    n = 0;
    while (!halt && !ill) begin
      word = m_mem[m_pc[12:3]];
      w = m_pc[2] ? word[63:32] : word[31:0];
      model_step(w, e, halt, ill);
      @(negedge clk);
      if (ill)
        check_value("retire_valid", 64'(retire_valid), 64'd0);
      else begin
        expect_retire(e);
        next_cycle();
      end
      n++;
      assert (n < 200) else stop_with_error("program ran past its step limit");
    end
    settle_in(end_state);
  endtask

  task automatic check_idle();
    repeat (5) begin
      @(negedge clk);
      check_value("state", 64'(state), 64'(rv_core_pkg::idle));
      check_value("retire_valid", 64'(retire_valid), 64'd0);
    end
    next_cycle();
  endtask

  // random addi/add/lui over x0..x7
  task automatic random_alu();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    prog.delete();
    for (int i = 0; i < 24; i++) begin
      rd = 5'(rand_bits(3));
      rs1 = 5'(rand_bits(3));
      rs2 = 5'(rand_bits(3));
      case (2'(rand_bits(2)))
        2'd0: prog.push_back(u_type(rv_isa_pkg::lui, rd, 20'(rand_bits(20))));
        2'd1: prog.push_back(r_type(7'd0, rd, rs1, rs2));
        default: prog.push_back(i_type(rv_isa_pkg::op_imm, rd, rs1, 3'd0, 12'(rand_bits(12))));
      endcase
    end
    prog.push_back(rv_isa_pkg::ebreak_word);
    load_program();
    run_program(rv_core_pkg::halted);
  endtask

  // jal at pc 8 skips two zero words, which would trap
  task automatic jump_upper();
    prog.delete();
    prog.push_back(i_type(rv_isa_pkg::op_imm, 5'd2, 5'd0, 3'd0, 12'(rand_bits(12))));
    prog.push_back(u_type(rv_isa_pkg::auipc, 5'd5, 20'(rand_bits(20))));
    prog.push_back(j_type(5'd1, 21'd12));
    prog.push_back(32'd0);
    prog.push_back(32'd0);
    prog.push_back(r_type(7'd0, 5'd6, 5'd1, 5'd5));
    prog.push_back(rv_isa_pkg::ebreak_word);
    load_program();
    run_program(rv_core_pkg::halted);
  endtask

  // x5 = 0x1000 store area, x7 = 0x1800 preloaded source words
  task automatic store_load();
    logic [11:0] off;
    prog.delete();
    prog.push_back(u_type(rv_isa_pkg::lui, 5'd5, 20'd1));
    prog.push_back(u_type(rv_isa_pkg::lui, 5'd7, 20'd2));
    prog.push_back(i_type(rv_isa_pkg::op_imm, 5'd7, 5'd7, 3'd0, 12'h800));
    for (int i = 0; i < 4; i++) begin
      write_word(32'(768 + i), rand_bits(64));
      off = 12'(rand_bits(8) << 3);
      prog.push_back(i_type(rv_isa_pkg::load, 5'(10 + i), 5'd7, 3'd3, 12'(8 * i)));
      prog.push_back(s_type(5'd5, 5'(10 + i), off));
      prog.push_back(i_type(rv_isa_pkg::load, 5'(20 + i), 5'd5, 3'd3, off));
    end
    prog.push_back(rv_isa_pkg::ebreak_word);
    load_program();
    run_program(rv_core_pkg::halted);
  endtask

  // start from halted reruns the last program from pc_reset
  task automatic halt_rerun();
    run_program(rv_core_pkg::halted);
  endtask

  task automatic trap_restart();
    prog.delete();
    prog.push_back(i_type(rv_isa_pkg::op_imm, 5'd1, 5'd0, 3'd0, 12'(rand_bits(12))));
    prog.push_back(i_type(rv_isa_pkg::op_imm, 5'd2, 5'd1, 3'd0, 12'(rand_bits(12))));
    // sub is outside the subset
    prog.push_back(r_type(7'h20, 5'd3, 5'd1, 5'd2));
    prog.push_back(rv_isa_pkg::ebreak_word);
    load_program();
    run_program(rv_core_pkg::trapped);
    // patch the trapping slot with ebreak
    prog[2] = rv_isa_pkg::ebreak_word;
    load_program();
    run_program(rv_core_pkg::halted);
  endtask

  initial begin
    arst_n = 1'b0;
    start = 1'b0;
    load = '0;
    for (int i = 0; i < 32; i++) begin
      m_x[i] = 64'd0;
    end
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;
    check_idle();
    random_alu();
    jump_upper();
    store_load();
    halt_rerun();
    trap_restart();
    $display("Test OK");
    $finish;
  end

endmodule

/* rv_core_top.f */
rv_isa_pkg.sv
rv_core_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_memory.sv
rv_pc_counter.sv
rv_core_ctrl.sv
rv_core_top.sv
tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the rv64 core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_rv_core -f rv_core_top.f -o tb_rv_core \
  && ./obj_dir/tb_rv_core > sim.log 2>&1 \
  || echo "build or simulation run failed"
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
